// File: be_pkg.sv
/* Backend redirect control types */
package be_pkg;

  localparam int vaddr_width     = 39;
  localparam int metadata_width  = 16;
  localparam int priv_width      = 2;
  localparam int instr_width     = 32;
  localparam int pte_leaf_width  = 53;
  localparam int cmd_queue_depth = 4;
  localparam int cmd_ptr_width   = $clog2(cmd_queue_depth);

  typedef logic [vaddr_width-1:0]    vaddr_t;
  typedef logic [metadata_width-1:0] metadata_t;
  typedef logic [priv_width-1:0]     priv_t;
  typedef logic [instr_width-1:0]    instr_t;
  typedef logic [pte_leaf_width-1:0] pte_leaf_t;

  typedef enum logic [2:0] {
    e_op_state_reset,
    e_op_itlb_fill,
    e_op_itlb_fence,
    e_op_pc_redirect,
    e_op_wait,
    e_op_icache_fence,
    e_op_icache_fill,
    e_op_attaboy
  } fe_opcode_e;

  typedef enum logic [2:0] {
    e_subop_translation_switch,
    e_subop_eret,
    e_subop_trap,
    e_subop_interrupt,
    e_subop_branch_mispredict
  } redirect_subop_e;

  typedef enum logic [1:0] {
    e_not_a_branch,
    e_pred_taken,
    e_pred_ntaken
  } mispredict_reason_e;

  // Operand carries the PTE on ITLB fills and the instruction on icache fills
  typedef struct packed {
    fe_opcode_e         opcode;
    vaddr_t             npc;
    redirect_subop_e    subop;
    priv_t              priv;
    logic               translation_en;
    mispredict_reason_e reason;
    logic               taken;
    metadata_t          metadata;
    pte_leaf_t          operand;
  } fe_cmd_s;

  typedef struct packed {
    vaddr_t    pc;
    metadata_t metadata;
  } issue_pkt_s;

  typedef struct packed {
    logic   v;
    logic   branch;
    logic   btaken;
    vaddr_t npc;
  } br_pkt_s;

  typedef struct packed {
    logic      npc_w_v;
    vaddr_t    npc;
    vaddr_t    vaddr;
    priv_t     priv_n;
    logic      translation_en_n;
    pte_leaf_t pte_leaf;
    instr_t    instr;
    logic      unfreeze;
    logic      itlb_fill_v;
    logic      sfence;
    logic      csrw;
    logic      wfi;
    logic      fencei;
    logic      icache_miss;
    logic      eret;
    logic      exception;
    logic      interrupt;
  } commit_pkt_s;

  typedef enum logic [1:0] {
    e_freeze,
    e_run,
    e_fence,
    e_wait
  } be_state_e;

endpackage

// File: be_commit_cmd_encoder.sv
/* Commit event to frontend command encoder */
`timescale 1ns/100ps

module be_commit_cmd_encoder
  (input  be_pkg::commit_pkt_s commit_pkt_i
   , input  be_pkg::vaddr_t    npc_i
   , output be_pkg::fe_cmd_s   cmd_o
   , output logic              cmd_v_o
   );

  always_comb
  begin
    cmd_o   = '0;
    cmd_v_o = 1'b1;

    if (commit_pkt_i.unfreeze)
    begin
      cmd_o.opcode         = be_pkg::e_op_state_reset;
      cmd_o.npc            = npc_i;
      cmd_o.priv           = commit_pkt_i.priv_n;
      cmd_o.translation_en = commit_pkt_i.translation_en_n;
    end
    else if (commit_pkt_i.itlb_fill_v)
    begin
      // Fills always restart at the faulting address
      cmd_o.opcode  = be_pkg::e_op_itlb_fill;
      cmd_o.npc     = commit_pkt_i.vaddr;
      cmd_o.operand = commit_pkt_i.pte_leaf;
    end
    else if (commit_pkt_i.sfence)
    begin
      cmd_o.opcode = be_pkg::e_op_itlb_fence;
      cmd_o.npc    = commit_pkt_i.npc;
    end
    else if (commit_pkt_i.csrw)
    begin
      cmd_o.opcode         = be_pkg::e_op_pc_redirect;
      cmd_o.npc            = commit_pkt_i.npc;
      cmd_o.subop          = be_pkg::e_subop_translation_switch;
      cmd_o.translation_en = commit_pkt_i.translation_en_n;
    end
    else if (commit_pkt_i.wfi)
    begin
      cmd_o.opcode = be_pkg::e_op_wait;
      cmd_o.npc    = commit_pkt_i.npc;
    end
    else if (commit_pkt_i.fencei)
    begin
      cmd_o.opcode = be_pkg::e_op_icache_fence;
      cmd_o.npc    = commit_pkt_i.npc;
    end
    else if (commit_pkt_i.icache_miss)
    begin
      cmd_o.opcode  = be_pkg::e_op_icache_fill;
      cmd_o.npc     = commit_pkt_i.vaddr;
      cmd_o.operand = be_pkg::pte_leaf_t'(commit_pkt_i.instr);
    end
    else if (commit_pkt_i.eret)
    begin
      cmd_o.opcode         = be_pkg::e_op_pc_redirect;
      cmd_o.npc            = commit_pkt_i.npc;
      cmd_o.subop          = be_pkg::e_subop_eret;
      cmd_o.priv           = commit_pkt_i.priv_n;
      cmd_o.translation_en = commit_pkt_i.translation_en_n;
    end
    else if (commit_pkt_i.exception || commit_pkt_i.interrupt)
    begin
      // Exception wins when both arrive together
      cmd_o.opcode         = be_pkg::e_op_pc_redirect;
      cmd_o.npc            = commit_pkt_i.npc;
      cmd_o.subop          = commit_pkt_i.exception ? be_pkg::e_subop_trap
                                                    : be_pkg::e_subop_interrupt;
      cmd_o.priv           = commit_pkt_i.priv_n;
      cmd_o.translation_en = commit_pkt_i.translation_en_n;
    end
    else
    begin
      cmd_v_o = 1'b0;
    end
  end

endmodule

// File: be_cmd_queue.sv
/* Frontend command queue */
`timescale 1ns/100ps

module be_cmd_queue
  (input  logic              clk_i
   , input  logic            reset_i
   , input  be_pkg::fe_cmd_s cmd_i
   , input  logic            cmd_v_i
   , output be_pkg::fe_cmd_s cmd_o
   , output logic            cmd_v_o
   , input  logic            pop_i
   , output logic            empty_n_o
   , output logic            empty_r_o
   , output logic            full_n_o
   , output logic            full_r_o
   );

  be_pkg::fe_cmd_s                  mem [be_pkg::cmd_queue_depth];
  logic [be_pkg::cmd_ptr_width-1:0] rd_ptr_r;
  logic [be_pkg::cmd_ptr_width-1:0] wr_ptr_r;
  logic [be_pkg::cmd_ptr_width:0]   count_r;
  logic [be_pkg::cmd_ptr_width:0]   count_n;
  logic                             wr_en;
  logic                             rd_en;

  assign wr_en = cmd_v_i & ~full_r_o;
  assign rd_en = pop_i & ~empty_r_o;

  always_comb
  begin
    count_n = count_r;
    if (wr_en && !rd_en)
      count_n = count_r + 1'b1;
    else if (rd_en && !wr_en)
      count_n = count_r - 1'b1;
  end

  assign empty_n_o = (count_n == '0);
  assign full_n_o  = (count_n == (be_pkg::cmd_ptr_width+1)'(be_pkg::cmd_queue_depth));

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_ptr_r  <= '0;
      wr_ptr_r  <= '0;
      count_r   <= '0;
      empty_r_o <= 1'b1;
      full_r_o  <= 1'b0;
    end
    else
    begin
      // Depth is a power of two so the pointers wrap naturally
      if (wr_en)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (rd_en)
        rd_ptr_r <= rd_ptr_r + 1'b1;
      count_r   <= count_n;
      empty_r_o <= empty_n_o;
      full_r_o  <= full_n_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      mem[wr_ptr_r] <= cmd_i;
  end

  assign cmd_o   = mem[rd_ptr_r];
  assign cmd_v_o = ~empty_r_o;

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_r_o);
  a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> !full_r_o);

endmodule

// File: be_director.sv
/* Backend PC director */
`timescale 1ns/100ps

module be_director
  (input  logic                 clk_i
   , input  logic               reset_i
   , input  be_pkg::issue_pkt_s issue_pkt_i
   , input  logic               dispatch_v_i
   , input  be_pkg::br_pkt_s    br_pkt_i
   , input  be_pkg::commit_pkt_s commit_pkt_i
   , input  logic               freeze_i
   , input  logic               irq_waiting_i
   , output be_pkg::vaddr_t     expected_npc_o
   , output logic               poison_isd_o
   , output logic               clear_iss_o
   , output logic               suppress_iss_o
   , output logic               unfreeze_o
   , output be_pkg::fe_cmd_s    q_cmd_o
   , output logic               q_cmd_v_o
   , input  logic               q_empty_r_i
   , input  logic               q_full_r_i
   );

  be_pkg::be_state_e state_r;
  be_pkg::be_state_e state_n;
  be_pkg::vaddr_t    npc_r;
  be_pkg::vaddr_t    npc_n;
  logic              npc_w_v;
  logic              branch_pending_r;
  logic              taken_pending_r;
  logic              last_branch;
  logic              last_taken;
  logic              npc_mismatch;
  logic              npc_match;
  logic              is_run;
  be_pkg::fe_cmd_s   commit_cmd;
  logic              commit_cmd_v;
  logic              cmd_nonattaboy_v;

  // Commit redirect overrides the execute-stage branch target
  assign npc_w_v = commit_pkt_i.npc_w_v | br_pkt_i.v;
  assign npc_n   = commit_pkt_i.npc_w_v ? commit_pkt_i.npc : br_pkt_i.npc;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      npc_r <= '0;
    else if (npc_w_v)
      npc_r <= npc_n;
  end

  assign expected_npc_o = npc_w_v ? npc_n : npc_r;

  assign npc_mismatch = dispatch_v_i & (expected_npc_o != issue_pkt_i.pc);
  assign npc_match    = dispatch_v_i & (expected_npc_o == issue_pkt_i.pc);
  assign poison_isd_o = commit_pkt_i.npc_w_v | npc_mismatch;

  // Branch outcome held until the next instruction dispatches
  always_ff @(posedge clk_i)
  begin
    if (reset_i || dispatch_v_i)
    begin
      branch_pending_r <= 1'b0;
      taken_pending_r  <= 1'b0;
    end
    else if (br_pkt_i.v)
    begin
      branch_pending_r <= branch_pending_r | br_pkt_i.branch;
      taken_pending_r  <= taken_pending_r | br_pkt_i.btaken;
    end
  end

  assign last_branch = branch_pending_r | (br_pkt_i.v & br_pkt_i.branch);
  assign last_taken  = taken_pending_r | (br_pkt_i.v & br_pkt_i.btaken);

  be_commit_cmd_encoder u_commit_cmd_encoder
    (.commit_pkt_i(commit_pkt_i)
     , .npc_i(npc_n)
     , .cmd_o(commit_cmd)
     , .cmd_v_o(commit_cmd_v)
     );

  assign is_run = (state_r == be_pkg::e_run);

  always_comb
  begin
    q_cmd_o   = commit_cmd;
    q_cmd_v_o = commit_cmd_v;
    if (!commit_cmd_v && npc_mismatch)
    begin
      q_cmd_o          = '0;
      q_cmd_o.opcode   = be_pkg::e_op_pc_redirect;
      q_cmd_o.npc      = expected_npc_o;
      q_cmd_o.subop    = be_pkg::e_subop_branch_mispredict;
      q_cmd_o.metadata = issue_pkt_i.metadata;
      q_cmd_o.reason   = !last_branch ? be_pkg::e_not_a_branch
                       : last_taken   ? be_pkg::e_pred_taken
                                      : be_pkg::e_pred_ntaken;
      q_cmd_v_o        = ~q_full_r_i & is_run;
    end
    else if (!commit_cmd_v && npc_match && last_branch)
    begin
      q_cmd_o          = '0;
      q_cmd_o.opcode   = be_pkg::e_op_attaboy;
      q_cmd_o.npc      = expected_npc_o;
      q_cmd_o.taken    = last_taken;
      q_cmd_o.metadata = issue_pkt_i.metadata;
      q_cmd_v_o        = ~q_full_r_i & is_run;
    end
  end

  assign cmd_nonattaboy_v = q_cmd_v_o & (q_cmd_o.opcode != be_pkg::e_op_attaboy);

  always_comb
  begin
    state_n = state_r;
    unique case (state_r)
      be_pkg::e_run:
        if (commit_pkt_i.wfi)
          state_n = be_pkg::e_wait;
        else if (cmd_nonattaboy_v)
          state_n = be_pkg::e_fence;
        else if (freeze_i)
          state_n = be_pkg::e_freeze;
      be_pkg::e_wait:
        if (irq_waiting_i)
          state_n = be_pkg::e_fence;
      be_pkg::e_fence:
        if (q_empty_r_i)
          state_n = be_pkg::e_run;
      default:
        if (commit_pkt_i.unfreeze)
          state_n = be_pkg::e_run;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= be_pkg::e_freeze;
    else
      state_r <= state_n;
  end

  assign suppress_iss_o = ~is_run;
  assign clear_iss_o    = (state_r == be_pkg::e_fence) & q_empty_r_i;
  assign unfreeze_o     = (state_r == be_pkg::e_freeze) & ~freeze_i;

  a_commit_room: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_cmd_v |-> !q_full_r_i);

endmodule

// File: be_fe_cmd_port.sv
/* Four-phase frontend command port */
`timescale 1ns/100ps

module be_fe_cmd_port
  (input  logic              clk_i
   , input  logic            reset_i
   , input  be_pkg::fe_cmd_s cmd_i
   , input  logic            cmd_v_i
   , output logic            pop_o
   , output be_pkg::fe_cmd_s fe_cmd_o
   , output logic            fe_req_o
   , input  logic            fe_ack_i
   );

  typedef enum logic [1:0] {e_idle, e_req, e_release} port_state_e;

  port_state_e     state_r;
  port_state_e     state_n;
  be_pkg::fe_cmd_s cmd_r;
  logic            load;

  // Start only once the previous ack has fully dropped
  assign load = (state_r == e_idle) & cmd_v_i & ~fe_ack_i;

  always_comb
  begin
    state_n = state_r;
    unique case (state_r)
      e_idle:    if (load) state_n = e_req;
      e_req:     if (fe_ack_i) state_n = e_release;
      e_release: if (!fe_ack_i) state_n = e_idle;
      default:   state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_idle;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
      cmd_r <= cmd_i;
  end

  assign fe_req_o = (state_r == e_req);
  assign fe_cmd_o = cmd_r;
  assign pop_o    = (state_r == e_release) & ~fe_ack_i;

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    fe_req_o |=> !fe_req_o || $stable(fe_cmd_o));

endmodule

// File: be_director_top.sv
/* Backend redirect control top */
`timescale 1ns/100ps

module be_director_top
  (input  logic                  clk_i
   , input  logic                reset_i
   , input  be_pkg::issue_pkt_s  issue_pkt_i
   , input  logic                dispatch_v_i
   , input  be_pkg::br_pkt_s     br_pkt_i
   , input  be_pkg::commit_pkt_s commit_pkt_i
   , input  logic                freeze_i
   , input  logic                irq_waiting_i
   , output be_pkg::vaddr_t      expected_npc_o
   , output logic                poison_isd_o
   , output logic                clear_iss_o
   , output logic                suppress_iss_o
   , output logic                unfreeze_o
   , output be_pkg::fe_cmd_s     fe_cmd_o
   , output logic                fe_req_o
   , input  logic                fe_ack_i
   );

  be_pkg::fe_cmd_s q_cmd_in;
  logic            q_cmd_in_v;
  be_pkg::fe_cmd_s q_head;
  logic            q_head_v;
  logic            q_pop;
  logic            q_empty_r;
  logic            q_full_r;

  be_director u_director
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .issue_pkt_i(issue_pkt_i)
     , .dispatch_v_i(dispatch_v_i)
     , .br_pkt_i(br_pkt_i)
     , .commit_pkt_i(commit_pkt_i)
     , .freeze_i(freeze_i)
     , .irq_waiting_i(irq_waiting_i)
     , .expected_npc_o(expected_npc_o)
     , .poison_isd_o(poison_isd_o)
     , .clear_iss_o(clear_iss_o)
     , .suppress_iss_o(suppress_iss_o)
     , .unfreeze_o(unfreeze_o)
     , .q_cmd_o(q_cmd_in)
     , .q_cmd_v_o(q_cmd_in_v)
     , .q_empty_r_i(q_empty_r)
     , .q_full_r_i(q_full_r)
     );

  be_cmd_queue u_cmd_queue
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .cmd_i(q_cmd_in)
     , .cmd_v_i(q_cmd_in_v)
     , .cmd_o(q_head)
     , .cmd_v_o(q_head_v)
     , .pop_i(q_pop)
     , .empty_n_o()
     , .empty_r_o(q_empty_r)
     , .full_n_o()
     , .full_r_o(q_full_r)
     );

  be_fe_cmd_port u_fe_cmd_port
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .cmd_i(q_head)
     , .cmd_v_i(q_head_v)
     , .pop_o(q_pop)
     , .fe_cmd_o(fe_cmd_o)
     , .fe_req_o(fe_req_o)
     , .fe_ack_i(fe_ack_i)
     );

endmodule

// File: tb_be_director_top.sv
/* Redirect control testbench */
`timescale 1ns/100ps

module tb_be_director_top;

  logic                clk_i = 1'b0;
  logic                reset_i;
  be_pkg::issue_pkt_s  issue_pkt;
  logic                dispatch_v;
  be_pkg::br_pkt_s     br_pkt;
  be_pkg::commit_pkt_s commit_pkt;
  logic                freeze;
  logic                irq_waiting;
  be_pkg::vaddr_t      expected_npc;
  logic                poison_isd;
  logic                clear_iss;
  logic                suppress_iss;
  logic                unfreeze;
  be_pkg::fe_cmd_s     fe_cmd;
  logic                fe_req;
  logic                fe_ack;

  be_pkg::fe_cmd_s     rx_q[$];
  int                  rx_total;
  int                  error_count;
  int                  test_count;
  int                  test_fail_count;
  logic [31:0]         lfsr_r;
  logic                slow_fe;
  int                  fe_phase;
  int                  fe_count;
  int                  fe_hold;

  be_director_top u_be_director_top
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .issue_pkt_i(issue_pkt)
     , .dispatch_v_i(dispatch_v)
     , .br_pkt_i(br_pkt)
     , .commit_pkt_i(commit_pkt)
     , .freeze_i(freeze)
     , .irq_waiting_i(irq_waiting)
     , .expected_npc_o(expected_npc)
     , .poison_isd_o(poison_isd)
     , .clear_iss_o(clear_iss)
     , .suppress_iss_o(suppress_iss)
     , .unfreeze_o(unfreeze)
     , .fe_cmd_o(fe_cmd)
     , .fe_req_o(fe_req)
     , .fe_ack_i(fe_ack)
     );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  task automatic pick_delay(output int delay);
    int i;
    delay = 0;
    for (i = 0; i < 2; i++)
    begin
      delay  = (delay << 1) | int'(lfsr_r[0]);
      lfsr_r = lfsr_step(lfsr_r);
    end
    if (slow_fe)
      delay = delay + 5;
  endtask

  // Frontend side of the four-phase handshake
  always @(posedge clk_i)
  begin
    #10;
    if (reset_i)
    begin
      fe_ack   = 1'b0;
      fe_phase = 0;
    end
    else
    begin
      case (fe_phase)
        0:
          if (fe_req)
          begin
            rx_q.push_back(fe_cmd);
            rx_total++;
            pick_delay(fe_count);
            fe_phase = 1;
          end
        1:
          if (fe_count == 0)
          begin
            fe_ack   = 1'b1;
            fe_hold  = 0;
            fe_phase = 2;
          end
          else
            fe_count--;
        2:
        begin
          fe_hold++;
          if (!fe_req)
          begin
            pick_delay(fe_count);
            fe_phase = 3;
          end
          else if (fe_hold == 4)
          begin
            $display("Frontend model: req still high 4 cycles after ack");
            error_count++;
          end
        end
        default:
          if (fe_count == 0)
          begin
            fe_ack   = 1'b0;
            fe_phase = 0;
          end
          else
            fe_count--;
      endcase
    end
  end

  // Packets are valid for one cycle only
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
    dispatch_v = 1'b0;
    br_pkt     = '0;
    commit_pkt = '0;
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("** Error %s: %s expected %0h, actual %0h", test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic wait_cmd(input string test, output be_pkg::fe_cmd_s cmd, output logic ok);
    int n;
    ok  = 1'b0;
    cmd = '0;
    for (n = 0; n < 80 && !ok; n++)
    begin
      next_cycle();
      #40;
      if (rx_q.size() != 0)
      begin
        cmd = rx_q.pop_front();
        ok  = 1'b1;
      end
    end
    if (!ok)
    begin
      $display("%s: no frontend command arrived within 80 cycles", test);
      error_count++;
    end
  endtask

  task automatic wait_run(input string test);
    int n;
    for (n = 0; n < 80 && suppress_iss; n++)
      next_cycle();
    if (suppress_iss)
    begin
      $display("%s: issue still suppressed after 80 cycles", test);
      error_count++;
    end
  endtask

  task automatic report_test(input string test, input int errors_before);
    test_count++;
    if (error_count == errors_before)
      $display("%s: PASS", test);
    else
    begin
      $display("%s: FAIL", test);
      test_fail_count++;
    end
  endtask

  task automatic test_unfreeze();
    string           test = "unfreeze";
    int              errs;
    be_pkg::fe_cmd_s cmd;
    logic            ok;
    be_pkg::vaddr_t  x;
    errs = error_count;
    x    = 39'h00_8000_0000;
    check_value(test, "suppress_iss_o after reset", 1, suppress_iss);
    check_value(test, "fe_req_o after reset", 0, fe_req);
    check_value(test, "clear_iss_o after reset", 0, clear_iss);
    // Frozen with freeze_i low
    check_value(test, "unfreeze_o after reset", 1, unfreeze);
    next_cycle();
    commit_pkt.unfreeze = 1'b1;
    commit_pkt.npc_w_v  = 1'b1;
    commit_pkt.npc      = x;
    wait_cmd(test, cmd, ok);
    if (ok)
    begin
      check_value(test, "opcode", be_pkg::e_op_state_reset, cmd.opcode);
      check_value(test, "npc", x, cmd.npc);
    end
    wait_run(test);
    check_value(test, "unfreeze_o while running", 0, unfreeze);
    report_test(test, errs);
  endtask

  task automatic test_attaboy();
    string           test = "attaboy";
    int              errs;
    be_pkg::fe_cmd_s cmd;
    logic            ok;
    be_pkg::vaddr_t  a;
    errs = error_count;
    a    = 39'h00_8000_0040;
    next_cycle();
    br_pkt.v      = 1'b1;
    br_pkt.branch = 1'b1;
    br_pkt.btaken = 1'b1;
    br_pkt.npc    = a;
    next_cycle();
    dispatch_v         = 1'b1;
    issue_pkt.pc       = a;
    issue_pkt.metadata = 16'hbeef;
    #40;
    check_value(test, "expected_npc_o", a, expected_npc);
    check_value(test, "poison_isd_o", 0, poison_isd);
    wait_cmd(test, cmd, ok);
    if (ok)
    begin
      check_value(test, "opcode", be_pkg::e_op_attaboy, cmd.opcode);
      check_value(test, "npc", a, cmd.npc);
      check_value(test, "taken", 1, cmd.taken);
      check_value(test, "metadata", 16'hbeef, cmd.metadata);
    end
    report_test(test, errs);
  endtask

  task automatic mispredict_case(input string test, input logic is_branch, input logic taken,
                                 input be_pkg::vaddr_t a, input be_pkg::vaddr_t b);
    be_pkg::fe_cmd_s            cmd;
    logic                       ok;
    be_pkg::mispredict_reason_e exp_reason;
    if (!is_branch)
      exp_reason = be_pkg::e_not_a_branch;
    else if (taken)
      exp_reason = be_pkg::e_pred_taken;
    else
      exp_reason = be_pkg::e_pred_ntaken;
    next_cycle();
    br_pkt.v      = 1'b1;
    br_pkt.branch = is_branch;
    br_pkt.btaken = is_branch & taken;
    br_pkt.npc    = a;
    next_cycle();
    dispatch_v         = 1'b1;
    issue_pkt.pc       = b;
    issue_pkt.metadata = 16'h1234;
    #40;
    check_value(test, "poison_isd_o", 1, poison_isd);
    check_value(test, "expected_npc_o", a, expected_npc);
    wait_cmd(test, cmd, ok);
    if (ok)
    begin
      check_value(test, "opcode", be_pkg::e_op_pc_redirect, cmd.opcode);
      check_value(test, "subop", be_pkg::e_subop_branch_mispredict, cmd.subop);
      check_value(test, "npc", a, cmd.npc);
      check_value(test, "reason", exp_reason, cmd.reason);
      check_value(test, "metadata", 16'h1234, cmd.metadata);
    end
    wait_run(test);
  endtask

  task automatic test_mispredict();
    string test = "mispredict";
    int    errs;
    errs = error_count;
    mispredict_case(test, 1'b1, 1'b1, 39'h00_8000_0100, 39'h00_8000_0104);
    mispredict_case(test, 1'b1, 1'b0, 39'h00_8000_0200, 39'h00_8000_0300);
    mispredict_case(test, 1'b0, 1'b0, 39'h00_8000_0400, 39'h00_8000_0408);
    report_test(test, errs);
  endtask

  task automatic commit_case(input string test, input be_pkg::commit_pkt_s pkt,
                             input be_pkg::fe_opcode_e exp_op,
                             input be_pkg::redirect_subop_e exp_subop);
    be_pkg::fe_cmd_s cmd;
    logic            ok;
    next_cycle();
    commit_pkt = pkt;
    wait_cmd(test, cmd, ok);
    if (ok)
    begin
      check_value(test, "opcode", exp_op, cmd.opcode);
      check_value(test, "npc", pkt.npc, cmd.npc);
      if (exp_op == be_pkg::e_op_pc_redirect)
        check_value(test, "subop", exp_subop, cmd.subop);
    end
    wait_run(test);
  endtask

  task automatic test_commit_priority();
    string               test = "commit_priority";
    int                  errs;
    be_pkg::commit_pkt_s p;
    errs = error_count;
    p        = '0;
    p.npc    = 39'h00_9000_0000;
    p.sfence = 1'b1;
    p.eret   = 1'b1;
    commit_case(test, p, be_pkg::e_op_itlb_fence, be_pkg::e_subop_eret);
    p           = '0;
    p.npc       = 39'h00_9000_0010;
    p.exception = 1'b1;
    p.interrupt = 1'b1;
    commit_case(test, p, be_pkg::e_op_pc_redirect, be_pkg::e_subop_trap);
    p             = '0;
    p.npc         = 39'h00_9000_0020;
    p.fencei      = 1'b1;
    p.icache_miss = 1'b1;
    commit_case(test, p, be_pkg::e_op_icache_fence, be_pkg::e_subop_trap);
    p           = '0;
    p.npc       = 39'h00_9000_0030;
    p.eret      = 1'b1;
    p.interrupt = 1'b1;
    commit_case(test, p, be_pkg::e_op_pc_redirect, be_pkg::e_subop_eret);
    report_test(test, errs);
  endtask

  task automatic test_wfi();
    string           test = "wfi";
    int              errs;
    int              n;
    be_pkg::fe_cmd_s cmd;
    logic            ok;
    logic            saw_clear;
    errs = error_count;
    next_cycle();
    commit_pkt.wfi = 1'b1;
    commit_pkt.npc = 39'h00_9000_0100;
    wait_cmd(test, cmd, ok);
    if (ok)
    begin
      check_value(test, "opcode", be_pkg::e_op_wait, cmd.opcode);
      check_value(test, "npc", 39'h00_9000_0100, cmd.npc);
    end
    for (n = 0; n < 6; n++)
    begin
      next_cycle();
      check_value(test, "suppress_iss_o while waiting", 1, suppress_iss);
    end
    next_cycle();
    irq_waiting = 1'b1;
    next_cycle();
    irq_waiting = 1'b0;
    saw_clear   = 1'b0;
    for (n = 0; n < 80 && suppress_iss; n++)
    begin
      if (clear_iss)
        saw_clear = 1'b1;
      next_cycle();
    end
    if (suppress_iss)
    begin
      $display("%s: issue did not resume within 80 cycles of the interrupt", test);
      error_count++;
    end
    else if (!saw_clear)
    begin
      $display("%s: clear_iss_o never pulsed before issue resumed", test);
      error_count++;
    end
    report_test(test, errs);
  endtask

  task automatic test_backpressure();
    string             test = "backpressure";
    int                errs;
    int                i;
    int                k;
    int                n;
    int                quiet;
    int                rx_at_end;
    int                next_idx;
    int                found;
    be_pkg::fe_cmd_s   cmd;
    be_pkg::vaddr_t    npcs [12];
    be_pkg::metadata_t metas [12];
    logic              takens [12];
    errs    = error_count;
    slow_fe = 1'b1;
    for (i = 0; i < 12; i++)
    begin
      next_cycle();
      npcs[i]            = 39'h00_8000_1000 + be_pkg::vaddr_t'(i * 8);
      metas[i]           = 16'h5a00 + 16'(i);
      takens[i]          = i[0];
      br_pkt.v           = 1'b1;
      br_pkt.branch      = 1'b1;
      br_pkt.btaken      = takens[i];
      br_pkt.npc         = npcs[i];
      dispatch_v         = 1'b1;
      issue_pkt.pc       = npcs[i];
      issue_pkt.metadata = metas[i];
      #40;
      check_value(test, "expected_npc_o", npcs[i], expected_npc);
      check_value(test, "poison_isd_o", 0, poison_isd);
    end
    next_cycle();
    dispatch_v         = 1'b1;
    issue_pkt.pc       = 39'h00_8000_0ff8;
    issue_pkt.metadata = 16'hdead;
    #40;
    check_value(test, "poison_isd_o on mismatch", 1, poison_isd);
    next_cycle();
    #40;
    rx_at_end = rx_total;
    quiet     = 0;
    for (n = 0; n < 400 && quiet < 4; n++)
    begin
      next_cycle();
      #40;
      if (!fe_req && !fe_ack && !suppress_iss)
        quiet++;
      else
        quiet = 0;
    end
    if (quiet < 4)
    begin
      $display("%s: command traffic did not drain within 400 cycles", test);
      error_count++;
    end
    if (rx_total - rx_at_end > be_pkg::cmd_queue_depth + 1)
    begin
      $display("** Error %s: outstanding commands expected at most %0d, actual %0d",
               test, be_pkg::cmd_queue_depth + 1, rx_total - rx_at_end);
      error_count++;
    end
    if (rx_q.size() == 0)
    begin
      $display("%s: no commands arrived during the burst", test);
      error_count++;
    end
    next_idx = 0;
    while (rx_q.size() != 0)
    begin
      cmd = rx_q.pop_front();
      if (cmd.opcode == be_pkg::e_op_attaboy)
      begin
        found = -1;
        for (k = next_idx; k < 12 && found < 0; k++)
          if (npcs[k] == cmd.npc)
            found = k;
        if (found < 0)
        begin
          $display("%s: attaboy for npc %0h is out of order or unknown", test, cmd.npc);
          error_count++;
        end
        else
        begin
          check_value(test, "attaboy metadata", metas[found], cmd.metadata);
          check_value(test, "attaboy taken", takens[found], cmd.taken);
          next_idx = found + 1;
        end
      end
      // A mispredict only fits at the very end of the burst
      else if (cmd.opcode == be_pkg::e_op_pc_redirect && rx_q.size() == 0)
      begin
        check_value(test, "subop", be_pkg::e_subop_branch_mispredict, cmd.subop);
        check_value(test, "npc", npcs[11], cmd.npc);
        check_value(test, "reason", be_pkg::e_not_a_branch, cmd.reason);
      end
      else
      begin
        $display("%s: unexpected command with opcode %0d", test, cmd.opcode);
        error_count++;
      end
    end
    slow_fe = 1'b0;
    report_test(test, errs);
  endtask

  initial
  begin
    reset_i         = 1'b1;
    issue_pkt       = '0;
    dispatch_v      = 1'b0;
    br_pkt          = '0;
    commit_pkt      = '0;
    freeze          = 1'b0;
    irq_waiting     = 1'b0;
    fe_ack          = 1'b0;
    lfsr_r          = 32'h0a9f_972b;
    slow_fe         = 1'b0;
    fe_phase        = 0;
    fe_count        = 0;
    fe_hold         = 0;
    rx_total        = 0;
    error_count     = 0;
    test_count      = 0;
    test_fail_count = 0;
    repeat (5) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    test_unfreeze();
    test_attaboy();
    test_mispredict();
    test_commit_priority();
    test_wfi();
    test_backpressure();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             test_count, test_fail_count, error_count);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: filelist.f
be_pkg.sv
be_commit_cmd_encoder.sv
be_cmd_queue.sv
be_director.sv
be_fe_cmd_port.sv
be_director_top.sv
tb_be_director_top.sv

// File: Bender.yml
package:
  name: be_director

sources:
  - be_pkg.sv
  - be_commit_cmd_encoder.sv
  - be_cmd_queue.sv
  - be_director.sv
  - be_fe_cmd_port.sv
  - be_director_top.sv
  - target: test
    files:
      - tb_be_director_top.sv
